// File: trojan_host_params.svh
/* Build-time sizing and seeds for the trojan packet host.
   Load word stays 64 bits, so packets wider than 8 bytes see the mask only in their low half */
`ifndef TROJAN_HOST_PARAMS_SVH
`define TROJAN_HOST_PARAMS_SVH

// Packet payload size in bytes
`define TH_PACKET_BYTES 8

// Buffer entries, kept a power of two so the pointers wrap on their own
`define TH_BUFFER_DEPTH 4

// Rolling key seed
`define TH_KEY_INIT 128'h123456789abcdef0fedcba0987654321

// LFSR seed, the pattern 1001 repeated
`define TH_LFSR_INIT 20'b10011001100110011001

// Feedback mask, taps at bits 19 and 16
`define TH_LFSR_TAPS 20'h90000

`endif

// File: trojan_host_pkg.sv
/* Shared types for the trojan packet host; widths follow the params header */
`include "trojan_host_params.svh"

package trojan_host_pkg;

    typedef logic [`TH_PACKET_BYTES*8-1:0] packet_t;  // Packet payload
    typedef logic [127:0] key_t;   // Trojan key
    typedef logic [63:0]  load_t;  // Trojan load word, fixed by Trojan0
    typedef logic [19:0]  lfsr_t;  // LFSR state
    typedef logic [3:0]   addr_t;  // Destination address

    typedef logic [$clog2(`TH_BUFFER_DEPTH)-1:0] buf_ptr_t;
    typedef logic [$clog2(`TH_BUFFER_DEPTH+1)-1:0] buf_count_t;

    // Incoming packet, dest in the top bits
    typedef struct packed {
        addr_t   dest;
        packet_t payload;
    } net_packet_s;

    // Host control states
    typedef enum logic [1:0] {
        st_idle,
        st_process,
        st_send
    } host_state_e;

endpackage

// File: packet_buffer.sv
/* Circular packet store; a push while full and a pop while empty are ignored.
   rdata always shows the head entry and is valid only while not empty */
`include "trojan_host_params.svh"

module packet_buffer import trojan_host_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  logic    pop,
    input  packet_t wdata,
    output packet_t rdata,
    output logic    full,
    output logic    empty
);

    packet_t    mem [`TH_BUFFER_DEPTH];
    buf_ptr_t   head;
    buf_ptr_t   tail;
    buf_count_t count;
    logic       do_push;
    logic       do_pop;

    assign full  = (count == buf_count_t'(`TH_BUFFER_DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Write at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail] <= wdata;
        end
    end

    assign rdata = mem[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;  // Wraps at depth
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// File: key_generator.sv
/* Rolling 128-bit key, seeded from TH_KEY_INIT.
   Each advance shifts left by a nibble and feeds back the old top nibble mixed with dest */
`include "trojan_host_params.svh"

module key_generator import trojan_host_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  advance,
    input  addr_t dest,
    output key_t  key
);

    key_t key_q;
    key_t key_rot;

    // Old top nibble wraps to the bottom, XORed with the destination
    assign key_rot = {key_q[123:0], key_q[127:124] ^ dest};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q <= `TH_KEY_INIT;
        end else if (advance) begin
            key_q <= key_rot;
        end
    end

    assign key = key_q;

endmodule

// File: trojan0.sv
/* Trojan0 leakage block with a free-running 20-bit Fibonacci LFSR mixed into the low key half.
   The LFSR steps on every clock after reset whatever the traffic */
`include "trojan_host_params.svh"

module trojan0 import trojan_host_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  key_t  key,
    output load_t load
);

    lfsr_t       lfsr;
    logic        feedback;
    logic [63:0] lfsr_rep;

    // XOR of the tapped bits goes in at the bottom
    assign feedback = ^(lfsr & lfsr_t'(`TH_LFSR_TAPS));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `TH_LFSR_INIT;
        end else begin
            lfsr <= {lfsr[18:0], feedback};
        end
    end

    // State repeated up to 64 bits
    assign lfsr_rep = {lfsr[3:0], {3{lfsr}}};

    // Leakage payload under study
    assign load = key[63:0] ^ lfsr_rep;

endmodule

// File: host_control.sv
/* Host FSM: accepts in st_idle only, drops on a full buffer with a one-cycle route_error.
   packet_out is head XOR load, registered on leaving st_send and marked by packet_ready */
module host_control import trojan_host_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  net_packet_s in_packet,
    output logic        in_ready,
    input  logic        out_ready,
    output packet_t     packet_out,
    output logic        packet_ready,
    output logic        route_error,
    output logic        buf_push,
    output logic        buf_pop,
    output packet_t     buf_wdata,
    input  packet_t     buf_rdata,
    input  logic        buf_full,
    input  logic        buf_empty,
    output logic        key_advance,
    output addr_t       key_dest,
    input  load_t       load
);

    host_state_e state;
    host_state_e state_next;
    logic        handshake;
    logic        drop;
    packet_t     masked;

    assign in_ready  = (state == st_idle);
    assign handshake = in_valid && in_ready;
    assign drop      = handshake && buf_full;  // Overflow

    // Every handshake rolls the key, dropped or not
    assign key_advance = handshake;
    assign key_dest    = in_packet.dest;

    assign buf_wdata = in_packet.payload;
    assign buf_push  = handshake && !buf_full;
    assign buf_pop   = (state == st_send);  // Buffer is never empty here

    // Load is 64 bits, sized to the packet width
    assign masked = buf_rdata ^ packet_t'(load);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (handshake || !buf_empty) begin
                    state_next = st_process;
                end
            end
            st_process: begin
                // Only commit to a send while the sink is ready
                if (!buf_empty && out_ready) begin
                    state_next = st_send;
                end else begin
                    state_next = st_idle;
                end
            end
            st_send: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            packet_ready <= 1'b0;
            route_error  <= 1'b0;
        end else begin
            state        <= state_next;
            packet_ready <= buf_pop;  // One-cycle pulse per send
            route_error  <= drop;
        end
    end

    // Head is masked with the load seen at the sending edge
    always_ff @(posedge clk) begin
        if (buf_pop) begin
            packet_out <= masked;
        end
    end

endmodule

// File: trojan_host_top.sv
/* Trojan packet host top level; routing by dest is not done, dest only feeds the key.
   Ready/valid on both sides, packet_ready is a pulse and packet_out holds until the next one */
module trojan_host_top import trojan_host_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  net_packet_s in_packet,
    output logic        in_ready,
    input  logic        out_ready,
    output packet_t     packet_out,
    output logic        packet_ready,
    output logic        route_error
);

    logic    buf_push;
    logic    buf_pop;
    packet_t buf_wdata;
    packet_t buf_rdata;
    logic    buf_full;
    logic    buf_empty;
    logic    key_advance;
    addr_t   key_dest;
    key_t    key;
    load_t   load;

    host_control u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_packet    (in_packet),
        .in_ready     (in_ready),
        .out_ready    (out_ready),
        .packet_out   (packet_out),
        .packet_ready (packet_ready),
        .route_error  (route_error),
        .buf_push     (buf_push),
        .buf_pop      (buf_pop),
        .buf_wdata    (buf_wdata),
        .buf_rdata    (buf_rdata),
        .buf_full     (buf_full),
        .buf_empty    (buf_empty),
        .key_advance  (key_advance),
        .key_dest     (key_dest),
        .load         (load)
    );

    packet_buffer u_buf (
        .clk   (clk),
        .rst   (rst),
        .push  (buf_push),
        .pop   (buf_pop),
        .wdata (buf_wdata),
        .rdata (buf_rdata),
        .full  (buf_full),
        .empty (buf_empty)
    );

    key_generator u_keygen (
        .clk     (clk),
        .rst     (rst),
        .advance (key_advance),
        .dest    (key_dest),
        .key     (key)
    );

    trojan0 u_trojan (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .load (load)
    );

endmodule

// File: trojan_host_properties.sv
/* Checker bound into trojan_host_top, with its own key, LFSR and packet queue.
   Assumes a four-entry buffer and a 64-bit packet */
`include "trojan_host_params.svh"

module trojan_host_properties import trojan_host_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input net_packet_s in_packet,
    input logic        in_ready,
    input logic        out_ready,
    input packet_t     packet_out,
    input logic        packet_ready,
    input logic        route_error
);

    key_t       shadow_key;
    lfsr_t      shadow_lfsr;
    packet_t    shadow_mem [4];
    buf_ptr_t   shadow_head;
    buf_ptr_t   shadow_tail;
    buf_count_t shadow_count;
    buf_count_t count_after_pop;
    load_t      shadow_load;
    packet_t    expected_out;
    logic       drop_q;
    logic       handshake;
    logic       push_ok;
    logic       fail_reset = 1'b0;
    logic       fail_data  = 1'b0;
    logic       fail_drop  = 1'b0;
    logic       fail_pulse = 1'b0;
    logic       fail_empty = 1'b0;
    logic       fail_sink  = 1'b0;
    logic       any_fail;

    assign handshake = in_valid && in_ready;
    // A send seen now frees its slot at this same edge
    assign count_after_pop = shadow_count - buf_count_t'(packet_ready);
    assign push_ok = handshake && (count_after_pop != buf_count_t'(4));

    // Low key half against the LFSR repeated every 20 bits
    always_comb begin
        for (int i = 0; i < 64; i++) begin
            shadow_load[i] = shadow_key[i] ^ shadow_lfsr[i % 20];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shadow_key   <= `TH_KEY_INIT;
            shadow_lfsr  <= `TH_LFSR_INIT;
            shadow_head  <= '0;
            shadow_tail  <= '0;
            shadow_count <= '0;
            drop_q       <= 1'b0;
            expected_out <= '0;
        end else begin
            shadow_lfsr  <= {shadow_lfsr[18:0], shadow_lfsr[19] ^ shadow_lfsr[16]};
            expected_out <= shadow_mem[shadow_head] ^ shadow_load;  // Valid at a sending edge
            drop_q       <= handshake && !push_ok;
            if (handshake) begin
                shadow_key <= {shadow_key[123:0], shadow_key[127:124] ^ in_packet.dest};
            end
            if (push_ok) begin
                shadow_mem[shadow_tail] <= in_packet.payload;
                shadow_tail <= shadow_tail + 1'b1;
            end
            if (packet_ready) shadow_head <= shadow_head + 1'b1;
            shadow_count <= count_after_pop + buf_count_t'(push_ok);
        end
    end

    assign any_fail = fail_reset | fail_data | fail_drop | fail_pulse | fail_empty | fail_sink;

    assert property (@(posedge clk) rst |-> in_ready && !packet_ready && !route_error)
        else begin
            fail_reset = 1'b1;
            $error("FAILED t=%0t in_ready/packet_ready/route_error = %b%b%b expected 100",
                   $time, $sampled(in_ready), $sampled(packet_ready), $sampled(route_error));
        end

    assert property (@(posedge clk) disable iff (rst) packet_ready |-> packet_out == expected_out)
        else begin
            fail_data = 1'b1;
            $error("FAILED t=%0t packet_out = %h expected %h",
                   $time, $sampled(packet_out), $sampled(expected_out));
        end

    assert property (@(posedge clk) disable iff (rst) route_error == drop_q)
        else begin
            fail_drop = 1'b1;
            $error("FAILED t=%0t route_error = %b expected %b",
                   $time, $sampled(route_error), $sampled(drop_q));
        end

    assert property (@(posedge clk) disable iff (rst) packet_ready |=> !packet_ready)
        else begin
            fail_pulse = 1'b1;
            $error("packet_ready stayed high for two cycles at t=%0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) packet_ready |-> shadow_count != '0)
        else begin
            fail_empty = 1'b1;
            $error("packet_ready rose with no packet buffered at t=%0t", $time);
        end

    // Sending starts only from st_process with the sink ready
    assert property (@(posedge clk) disable iff (rst) packet_ready |-> $past(out_ready, 2))
        else begin
            fail_sink = 1'b1;
            $error("A packet was sent while out_ready was low at t=%0t", $time);
        end

endmodule

bind trojan_host_top trojan_host_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_packet    (in_packet),
    .in_ready     (in_ready),
    .out_ready    (out_ready),
    .packet_out   (packet_out),
    .packet_ready (packet_ready),
    .route_error  (route_error)
);

// File: trojan_host_tb.sv
/* Testbench for trojan_host_top; the bound property checker does the checking.
   Inputs change 1 unit after the rising edge, every wait is bounded by WAIT_LIMIT cycles */
module trojan_host_tb import trojan_host_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        in_valid;
    net_packet_s in_packet;
    logic        in_ready;
    logic        out_ready;
    packet_t     packet_out;
    logic        packet_ready;
    logic        route_error;

    logic [31:0] data_state;
    logic [31:0] ready_state;
    int          ready_mode;  // 0 held low, 1 held high, 2 random
    int          hs_count;
    int          out_count;
    int          drop_count;

    trojan_host_top uut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_packet    (in_packet),
        .in_ready     (in_ready),
        .out_ready    (out_ready),
        .packet_out   (packet_out),
        .packet_ready (packet_ready),
        .route_error  (route_error)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Sink back-pressure
    always @(posedge clk) begin
        #1;
        if (ready_mode == 2) begin
            ready_state = lcg_next(ready_state);
            out_ready = ready_state[16];
        end else begin
            out_ready = (ready_mode == 1);
        end
    end

    // Sends and drops seen at the output, read between edges
    always @(negedge clk) begin
        if (!rst) begin
            if (packet_ready) out_count++;
            if (route_error) drop_count++;
        end
    end

    always @(negedge clk) begin
        if (uut.u_props.any_fail) begin
            $display("Simulation failed");
            $fatal(1, "The property checker reported a failure");
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Simulation failed");
        $fatal(1, "Timed out waiting for %s", what);
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;  // Picked up by the sink driver at this edge plus 1
        #1;
    endtask

    // Holds the packet on the input until the host takes it
    task automatic send_packet(input addr_t dest, input packet_t payload);
        int waited;
        waited = 0;
        in_packet.dest    = dest;
        in_packet.payload = payload;
        in_valid = 1'b1;
        while (!in_ready) begin
            if (waited == WAIT_LIMIT) abort_on_timeout("in_ready");
            @(posedge clk);
            #1;
            waited++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        hs_count++;
    endtask

    task automatic send_random(input bit with_gap);
        addr_t   dest;
        packet_t payload;
        data_state = lcg_next(data_state);
        dest = data_state[19:16];
        data_state = lcg_next(data_state);
        payload[63:32] = data_state;
        data_state = lcg_next(data_state);
        payload[31:0] = data_state;
        send_packet(dest, payload);
        if (with_gap) begin
            repeat (data_state[25:24]) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Every handshake ends as either a send or a drop
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (out_count + drop_count != hs_count) begin
            if (waited == WAIT_LIMIT) abort_on_timeout("the buffer to drain");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic wait_for_drop(input int drops_before);
        int waited;
        waited = 0;
        while (drop_count == drops_before) begin
            if (waited == WAIT_LIMIT) abort_on_timeout("route_error after the overflow");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    initial begin
        int i;
        int drops_before;
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_packet   = '0;
        out_ready   = 1'b0;
        ready_mode  = 0;
        data_state  = 32'h1c95;
        ready_state = 32'h1c95;
        hs_count    = 0;
        out_count   = 0;
        drop_count  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // In order delivery, sink always ready
        set_ready_mode(1);
        for (i = 0; i < 8; i++) send_random(1'b0);
        wait_drain();

        // Walk all destinations through the key
        for (i = 0; i < 16; i++) begin
            data_state = lcg_next(data_state);
            send_packet(addr_t'(i), {data_state, ~data_state});
        end
        wait_drain();

        // Stalled sink fills the buffer, the fifth packet overflows
        set_ready_mode(0);
        for (i = 0; i < 4; i++) send_random(1'b0);
        drops_before = drop_count;
        send_random(1'b0);
        wait_for_drop(drops_before);

        set_ready_mode(1);
        wait_drain();

        // Random back-pressure with gaps between packets
        set_ready_mode(2);
        for (i = 0; i < 24; i++) send_random(1'b1);
        wait_drain();

        if (uut.u_props.any_fail) begin
            $display("Simulation failed");
            $fatal(1, "The property checker reported a failure");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: trojan_host_top.f
+incdir+.
trojan_host_pkg.sv
packet_buffer.sv
key_generator.sv
trojan0.sv
host_control.sv
trojan_host_top.sv
trojan_host_properties.sv
trojan_host_tb.sv

// File: Makefile
# Verilator build and run for the trojan packet host
TOP := trojan_host_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "Run FAILED"; exit 1; fi

obj_dir/V$(TOP): $(wildcard *.sv *.svh) trojan_host_top.f
	verilator --binary --timing --assert -f trojan_host_top.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f trojan_host_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
